//--- hdl/ver_alulite.sv
`timescale 1ns/10ps
`default_nettype none

module ver_alulite (
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic                  en,
   input  wire ver_pkg::flow_bus_t    flow_in,
   input  wire ver_pkg::alu_conf_t    conf,
   output logic [ver_pkg::data_w-1:0] flow_out
);

   import ver_pkg::*;

   logic [data_w-1:0] op_a;
   logic [data_w-1:0] op_b;
   logic [data_w-1:0] op_a_reg;
   logic [data_w-1:0] op_b_reg;
   logic [data_w-1:0] op_a_int;
   logic              inv_a;
   logic [data_w:0]   a_ext;
   logic [data_w:0]   b_ext;
   logic [data_w:0]   sum;
   logic              b_lt_a;
   logic              loop_hold;
   logic [data_w-1:0] result;

   // operand selection straight from the flow bus
   assign op_a = flow_in[conf.sela];
   assign op_b = flow_in[conf.selb];

   // stage 1, operand registers
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op_a_reg <= '0;
         op_b_reg <= '0;
      end else if (en) begin
         op_a_reg <= op_a;
         op_b_reg <= op_b;
      end
   end

   // feedback replaces a
   assign op_a_int = conf.self_loop ? flow_out : op_a_reg;

   // subtract-type functions invert a and add a carry in
   always_comb begin
      case (conf.fn)
         fn_sub,
         fn_cmp_sig,
         fn_max,
         fn_min: begin
            inv_a = 1'b1;
         end
         default: begin
            inv_a = 1'b0;
         end
      endcase
   end

   // sign extended to 33 bits so the top bit is the true sign of b - a
   assign a_ext  = {op_a_int[data_w-1], op_a_int} ^ {(data_w+1){inv_a}};
   assign b_ext  = {op_b_reg[data_w-1], op_b_reg};
   assign sum    = b_ext + a_ext + {{data_w{1'b0}}, inv_a};
   assign b_lt_a = sum[data_w];

   // control bit carried in the registered a operand
   assign loop_hold = conf.self_loop & op_a_reg[data_w-1];

   always_comb begin
      result = sum[data_w-1:0];
      case (conf.fn)
         fn_or: begin
            result = op_a_int | op_b_reg;
         end
         fn_and: begin
            result = op_a_int & op_b_reg;
         end
         fn_cmp_sig: begin
            result[data_w-1] = b_lt_a;
         end
         fn_mux: begin
            if (op_a_reg[data_w-1])
               result = op_b_reg;
            else if (conf.self_loop)
               result = flow_out;
            else
               result = '0;
         end
         fn_sub: begin
            result = sum[data_w-1:0];
         end
         fn_add: begin
            // loads b instead of accumulating
            if (loop_hold)
               result = op_b_reg;
         end
         fn_max: begin
            result = b_lt_a ? op_a_int : op_b_reg;
            if (loop_hold)
               result = flow_out;
         end
         fn_min: begin
            result = b_lt_a ? op_b_reg : op_a_int;
            if (loop_hold)
               result = flow_out;
         end
      endcase
   end

   // stage 2, result register
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         flow_out <= '0;
      else if (en)
         flow_out <= result;
   end

   // configuration comes from the register block
   a_fn_known: assert property (
      @(posedge clk) disable iff (rst)
      !$isunknown(conf.fn)
   );

endmodule

`default_nettype wire

//--- hdl/ver_conf_regs.sv
`timescale 1ns/10ps
`default_nettype none

module ver_conf_regs (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire ver_pkg::wb_req_t            wb_req,
   output ver_pkg::wb_rsp_t                 wb_rsp,
   output ver_pkg::alu_conf_t               conf0,
   output ver_pkg::alu_conf_t               conf1,
   output logic [ver_pkg::data_w-1:0]       const0,
   output logic [ver_pkg::data_w-1:0]       const1,
   output logic                             run_load,
   output logic [ver_pkg::run_w-1:0]        run_count,
   input  wire logic [ver_pkg::run_w-1:0]   run_remaining,
   input  wire logic [ver_pkg::data_w-1:0]  out0,
   input  wire logic [ver_pkg::data_w-1:0]  out1
);

   import ver_pkg::*;

   logic              acc;
   logic              wr;
   logic              wr_run;
   logic              ack_q;
   logic [data_w-1:0] rdata;
   logic [data_w-1:0] rdata_q;

   // new access, the registered ack blocks a second one
   assign acc    = wb_req.cyc & wb_req.stb & ~ack_q;
   assign wr     = acc & wb_req.we;
   assign wr_run = wr & (wb_req.adr == adr_run);

   // read mux
   always_comb begin
      case (wb_req.adr)
         adr_const0: begin
            rdata = const0;
         end
         adr_const1: begin
            rdata = const1;
         end
         adr_conf0: begin
            rdata = data_w'(conf0);
         end
         adr_conf1: begin
            rdata = data_w'(conf1);
         end
         adr_run: begin
            rdata = data_w'(run_remaining);
         end
         adr_out0: begin
            rdata = out0;
         end
         adr_out1: begin
            rdata = out1;
         end
         default: begin
            rdata = '0;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ack_q    <= 1'b0;
         run_load <= 1'b0;
         const0   <= '0;
         const1   <= '0;
         conf0    <= '0;
         conf1    <= '0;
      end else begin
         ack_q    <= acc;
         run_load <= wr_run;
         if (wr) begin
            case (wb_req.adr)
               adr_const0: begin
                  const0 <= wb_req.dat_w;
               end
               adr_const1: begin
                  const1 <= wb_req.dat_w;
               end
               adr_conf0: begin
                  conf0 <= alu_conf_t'(wb_req.dat_w[conf_w-1:0]);
               end
               adr_conf1: begin
                  conf1 <= alu_conf_t'(wb_req.dat_w[conf_w-1:0]);
               end
               default: begin
               end
            endcase
         end
      end
   end

   // read data and run count, valid alongside ack and run_load
   always_ff @(posedge clk) begin
      if (acc)
         rdata_q <= rdata;
      if (wr_run)
         run_count <= wb_req.dat_w[run_w-1:0];
   end

   assign wb_rsp = '{ack: ack_q, dat_r: rdata_q};

   a_ack_single: assert property (
      @(posedge clk) disable iff (rst)
      ack_q |=> !ack_q
   );

   a_ack_after_req: assert property (
      @(posedge clk) disable iff (rst)
      ack_q |-> $past(wb_req.cyc && wb_req.stb)
   );

endmodule

`default_nettype wire

//--- hdl/ver_pkg.sv
`default_nettype none

package ver_pkg;

   // datapath widths
   localparam int data_w  = 32;
   localparam int n_slots = 4;
   localparam int sel_w   = 2;
   localparam int run_w   = 16;
   localparam int adr_w   = 3;

   // word addresses on the wishbone slave
   localparam logic [adr_w-1:0] adr_const0 = 3'd0;
   localparam logic [adr_w-1:0] adr_const1 = 3'd1;
   localparam logic [adr_w-1:0] adr_conf0  = 3'd2;
   localparam logic [adr_w-1:0] adr_conf1  = 3'd3;
   localparam logic [adr_w-1:0] adr_run    = 3'd4;
   localparam logic [adr_w-1:0] adr_out0   = 3'd5;
   localparam logic [adr_w-1:0] adr_out1   = 3'd6;

   // slot 0 const0, slot 1 const1, slot 2 alu0, slot 3 alu1
   typedef logic [n_slots-1:0][data_w-1:0] flow_bus_t;

   typedef enum logic [2:0] {
      fn_or      = 3'd0,
      fn_and     = 3'd1,
      fn_cmp_sig = 3'd2,
      fn_mux     = 3'd3,
      fn_sub     = 3'd4,
      fn_add     = 3'd5,
      fn_max     = 3'd6,
      fn_min     = 3'd7
   } alu_fn_t;

   typedef struct packed {
      logic [sel_w-1:0] sela;
      logic [sel_w-1:0] selb;
      logic             self_loop;
      alu_fn_t          fn;
   } alu_conf_t;

   localparam int conf_w = $bits(alu_conf_t);

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [adr_w-1:0]  adr;
      logic [data_w-1:0] dat_w;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic [data_w-1:0] dat_r;
   } wb_rsp_t;

endpackage

`default_nettype wire

//--- hdl/ver_run_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ver_run_ctrl (
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       run_load,
   input  wire logic [ver_pkg::run_w-1:0]  run_count,
   output logic                            en,
   output logic [ver_pkg::run_w-1:0]       remaining
);

   import ver_pkg::*;

   logic [run_w-1:0] cnt_next;

   // busy counts down and a load only lands when idle
   always_comb begin
      cnt_next = remaining;
      if (remaining != '0)
         cnt_next = remaining - 1'b1;
      else if (run_load)
         cnt_next = run_count;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         remaining <= '0;
         en        <= 1'b0;
      end else begin
         remaining <= cnt_next;
         en        <= (cnt_next != '0);
      end
   end

   a_en_busy: assert property (
      @(posedge clk) disable iff (rst)
      en == (remaining != '0)
   );

endmodule

`default_nettype wire

//--- hdl/ver_top.sv
`timescale 1ns/10ps
`default_nettype none

module ver_top (
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire ver_pkg::wb_req_t  wb_req,
   output ver_pkg::wb_rsp_t       wb_rsp
);

   import ver_pkg::*;

   logic [data_w-1:0] const0;
   logic [data_w-1:0] const1;
   logic [data_w-1:0] out0;
   logic [data_w-1:0] out1;
   alu_conf_t         conf0;
   alu_conf_t         conf1;
   logic              run_load;
   logic [run_w-1:0]  run_count;
   logic [run_w-1:0]  run_remaining;
   logic              en;
   flow_bus_t         flow;

   // slot 3 down to slot 0
   assign flow = {out1, out0, const1, const0};

   ver_conf_regs u_conf_regs (
      .clk           (clk),
      .rst           (rst),
      .wb_req        (wb_req),
      .wb_rsp        (wb_rsp),
      .conf0         (conf0),
      .conf1         (conf1),
      .const0        (const0),
      .const1        (const1),
      .run_load      (run_load),
      .run_count     (run_count),
      .run_remaining (run_remaining),
      .out0          (out0),
      .out1          (out1)
   );

   ver_run_ctrl u_run_ctrl (
      .clk       (clk),
      .rst       (rst),
      .run_load  (run_load),
      .run_count (run_count),
      .en        (en),
      .remaining (run_remaining)
   );

   ver_alulite u_alu0 (
      .clk      (clk),
      .rst      (rst),
      .en       (en),
      .flow_in  (flow),
      .conf     (conf0),
      .flow_out (out0)
   );

   ver_alulite u_alu1 (
      .clk      (clk),
      .rst      (rst),
      .en       (en),
      .flow_in  (flow),
      .conf     (conf1),
      .flow_out (out1)
   );

endmodule

`default_nettype wire

//--- tb.f
hdl/ver_pkg.sv
hdl/ver_alulite.sv
hdl/ver_conf_regs.sv
hdl/ver_run_ctrl.sv
hdl/ver_top.sv
verif/tb_top.sv

//--- verif/tb_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_top;

   import ver_pkg::*;

   localparam int n_edge     = 6;
   localparam int n_pairs    = n_edge + 200;
   // the tests take about 20 cycles per pair and a few hundred more
   localparam int max_cycles = 20000;

   logic    clk;
   logic    rst;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;
   int      cycles;
   int      n_checks;
   int      n_fail;
   int      test_base;

   ver_top i_ver_top (
      .clk    (clk),
      .rst    (rst),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("timeout: the tests did not finish within %0d cycles", max_cycles);
         $display("Something failed");
         $finish;
      end
   end

   // expected unit output after one enabled cycle with registered operands a and b
   function automatic logic [31:0] alu_ref(alu_fn_t fn, logic [31:0] a, logic [31:0] b,
                                           logic self_loop, logic [31:0] prev);
      logic [31:0] op_a;
      logic [31:0] diff;
      logic        b_lt_a;
      logic        hold;
      op_a   = self_loop ? prev : a;
      diff   = b - op_a;
      b_lt_a = $signed(b) < $signed(op_a);
      hold   = self_loop && a[31];
      case (fn)
         fn_or:      alu_ref = op_a | b;
         fn_and:     alu_ref = op_a & b;
         fn_cmp_sig: alu_ref = {b_lt_a, diff[30:0]};
         fn_mux:     alu_ref = a[31] ? b : (self_loop ? prev : 32'h0);
         fn_sub:     alu_ref = diff;
         fn_add:     alu_ref = hold ? b : op_a + b;
         fn_max:     alu_ref = hold ? prev : (b_lt_a ? op_a : b);
         default:    alu_ref = hold ? prev : (b_lt_a ? b : op_a);
      endcase
   endfunction

   function automatic logic [31:0] conf_word(logic [1:0] sela, logic [1:0] selb,
                                             logic self_loop, alu_fn_t fn);
      conf_word = {24'h0, sela, selb, self_loop, fn};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_fail++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_test(input string name);
      $display("%s: %0d errors", name, n_fail - test_base);
      test_base = n_fail;
   endtask

   task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
      @(negedge clk);
      wb_req.cyc   = 1'b1;
      wb_req.stb   = 1'b1;
      wb_req.we    = we;
      wb_req.adr   = adr;
      wb_req.dat_w = dat;
      @(negedge clk);
      while (!wb_rsp.ack)
         @(negedge clk);
      rdat       = wb_rsp.dat_r;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
   endtask

   task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      wb_access(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
      wb_access(1'b0, adr, 32'h0, dat);
   endtask

   task automatic wait_idle();
      logic [31:0] left;
      left = 32'h1;
      while (left != 0)
         wb_read(adr_run, left);
   endtask

   task automatic run_cycles(input int n);
      wb_write(adr_run, 32'(n));
      wait_idle();
   endtask

   task automatic edge_pair(input int i, output logic [31:0] a, output logic [31:0] b);
      case (i)
         0:       {a, b} = {32'h0000_0005, 32'h0000_0005};
         1:       {a, b} = {32'h7fff_ffff, 32'h8000_0000};
         2:       {a, b} = {32'h8000_0000, 32'h7fff_ffff};
         3:       {a, b} = {32'h8000_0000, 32'h8000_0000};
         4:       {a, b} = {32'h8000_0000, 32'h0000_0001};
         default: {a, b} = {32'hffff_ffff, 32'h0000_0001};
      endcase
   endtask

   initial begin
      int          i;
      int          n;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [31:0] r1;
      logic [31:0] prev;
      logic [31:0] exp;
      logic [2:0]  code;
      alu_fn_t     fn0;
      alu_fn_t     fn1;
      clk       = 1'b0;
      rst       = 1'b1;
      wb_req    = '0;
      cycles    = 0;
      n_checks  = 0;
      n_fail    = 0;
      test_base = 0;
      r         = $urandom(32'hb0e0_ec56);
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (i = 0; i < 8; i++) begin
         wb_read(i[2:0], r);
         check_value("reset readback", r, 32'h0);
      end
      a = $urandom;
      b = $urandom;
      wb_write(adr_const0, a);
      wb_write(adr_const1, b);
      wb_write(adr_conf0, 32'hffff_ff5a);
      wb_write(adr_conf1, b);
      wb_read(adr_const0, r);
      check_value("const0", r, a);
      wb_read(adr_const1, r);
      check_value("const1", r, b);
      wb_read(adr_conf0, r);
      check_value("conf0", r, 32'h0000_005a);
      wb_read(adr_conf1, r);
      check_value("conf1", r, {24'h0, b[7:0]});
      wb_write(adr_out0, 32'hdead_beef);
      wb_write(adr_out1, 32'h1234_5678);
      wb_write(3'd7, 32'hffff_ffff);
      wb_read(adr_out0, r);
      check_value("out0", r, 32'h0);
      wb_read(adr_out1, r);
      check_value("out1", r, 32'h0);
      wb_read(3'd7, r);
      check_value("address 7", r, 32'h0);
      report_test("register access");

      // alu0 reads const0 as a and alu1 the other way round
      for (i = 0; i < n_pairs; i++) begin
         if (i < n_edge) begin
            edge_pair(i, a, b);
         end else begin
            a = $urandom;
            b = $urandom;
         end
         code = i[2:0] + 3'd6;
         fn0  = alu_fn_t'(i[2:0]);
         fn1  = alu_fn_t'(code);
         wb_write(adr_const0, a);
         wb_write(adr_const1, b);
         wb_write(adr_conf0, conf_word(2'd0, 2'd1, 1'b0, fn0));
         wb_write(adr_conf1, conf_word(2'd1, 2'd0, 1'b0, fn1));
         run_cycles(2);
         wb_read(adr_out0, r);
         check_value("out0", r, alu_ref(fn0, a, b, 1'b0, 32'h0));
         wb_read(adr_out1, r);
         check_value("out1", r, alu_ref(fn1, b, a, 1'b0, 32'h0));
      end
      report_test("functions without self-loop");

      wb_read(adr_out0, prev);
      wb_read(adr_out1, r1);
      wb_write(adr_const0, $urandom);
      wb_write(adr_const1, $urandom);
      wb_read(adr_out0, r);
      check_value("out0", r, prev);
      wb_read(adr_out1, r);
      check_value("out1", r, r1);
      wb_write(adr_run, 32'd50);
      wb_read(adr_run, r1);
      wb_write(adr_run, 32'd3);
      wb_read(adr_run, r);
      // two accesses of two cycles each lie between the samples
      check_value("remaining", r, r1 - 32'd4);
      wait_idle();
      report_test("run control");

      a = $urandom & 32'h7fff_ffff;
      b = $urandom;
      wb_write(adr_const0, a);
      wb_write(adr_const1, b);
      wb_write(adr_conf0, conf_word(2'd0, 2'd1, 1'b1, fn_add));
      // one cycle loads the operand registers
      run_cycles(1);
      wb_read(adr_out0, prev);
      n   = 5 + ($urandom % 20);
      exp = prev;
      repeat (n) exp = alu_ref(fn_add, a, b, 1'b1, exp);
      run_cycles(n);
      wb_read(adr_out0, r);
      check_value("out0 accumulate", r, exp);
      wb_write(adr_const0, a | 32'h8000_0000);
      run_cycles(2);
      exp = alu_ref(fn_add, a, b, 1'b1, exp);
      exp = alu_ref(fn_add, a | 32'h8000_0000, b, 1'b1, exp);
      wb_read(adr_out0, r);
      check_value("out0 load", r, exp);
      report_test("self-loop accumulation");

      a = $urandom;
      b = $urandom;
      wb_write(adr_const0, a);
      wb_write(adr_const1, b);
      wb_write(adr_conf0, conf_word(2'd0, 2'd1, 1'b0, fn_sub));
      wb_write(adr_conf1, conf_word(2'd2, 2'd1, 1'b0, fn_max));
      run_cycles(6);
      exp = alu_ref(fn_sub, a, b, 1'b0, 32'h0);
      wb_read(adr_out0, r);
      check_value("out0 chain", r, exp);
      wb_read(adr_out1, r);
      check_value("out1 chain", r, alu_ref(fn_max, exp, b, 1'b0, 32'h0));

      // both units pass const0 with bit 31 set and then hold it
      a = $urandom | 32'h8000_0000;
      wb_write(adr_const0, a);
      wb_write(adr_conf0, conf_word(2'd0, 2'd0, 1'b0, fn_or));
      wb_write(adr_conf1, conf_word(2'd0, 2'd0, 1'b0, fn_or));
      run_cycles(2);
      b = $urandom;
      wb_write(adr_const1, b);
      wb_write(adr_conf0, conf_word(2'd0, 2'd1, 1'b1, fn_max));
      wb_write(adr_conf1, conf_word(2'd0, 2'd1, 1'b1, fn_min));
      run_cycles(4);
      wb_read(adr_out0, r);
      check_value("out0 max hold", r, alu_ref(fn_max, a, b, 1'b1, a));
      wb_read(adr_out1, r);
      check_value("out1 min hold", r, alu_ref(fn_min, a, b, 1'b1, a));

      wb_write(adr_conf0, conf_word(2'd0, 2'd1, 1'b0, fn_mux));
      wb_write(adr_conf1, conf_word(2'd0, 2'd1, 1'b1, fn_mux));
      run_cycles(2);
      wb_read(adr_out0, r);
      check_value("out0 mux", r, alu_ref(fn_mux, a, b, 1'b0, 32'h0));
      wb_read(adr_out1, prev);
      check_value("out1 mux", prev, alu_ref(fn_mux, a, b, 1'b1, a));
      a = a & 32'h7fff_ffff;
      wb_write(adr_const0, a);
      // a new b tells holding apart from selecting b
      b = ~b;
      wb_write(adr_const1, b);
      run_cycles(2);
      wb_read(adr_out0, r);
      check_value("out0 mux clear", r, alu_ref(fn_mux, a, b, 1'b0, 32'h0));
      wb_read(adr_out1, r);
      check_value("out1 mux hold", r, alu_ref(fn_mux, a, b, 1'b1, prev));
      report_test("chaining and hold");

      $display("checks: %0d passed, %0d failed", n_checks - n_fail, n_fail);
      if (n_fail == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
